// ==== uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

//************************************************************
// Line timing
//************************************************************
`define SYSCLK_RATE 25000000 // System clock in Hz
`define BAUD_RATE 1562500 // Serial line rate in bit/s

// Whole clocks per bit, no fractional part
`define CLKS_PER_BIT (`SYSCLK_RATE / `BAUD_RATE)

//************************************************************
// Frame format
//************************************************************
`define DATA_BITS 8 // LSB sent first
`define STOP_BITS 1 // 1 or 2

//************************************************************
// Buffering and self test
//************************************************************
`define FIFO_ADDR_BITS 4 // Depth is 2**FIFO_ADDR_BITS
`define FIFO_RTS_LEVEL 12 // RTS drops at this fill count
`define BIST_BYTES 16 // Pattern bytes per self test run

`endif

// ==== uartLinePkg.sv ====
`include "uart_params.svh"

// Serial line types shared by receiver, transmitter and top level
package uartLinePkg;

	// One character on the wire
	typedef logic [`DATA_BITS-1:0] uartData;

	// Data and stop bit index within a frame
	typedef logic [3:0] bitCount;

	// Receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE, // Waiting for falling edge
		RX_START, // Start bit qualify at mid-bit
		RX_DATA, // Data bits, LSB first
		RX_STOP // Stop bit check
	} rxState;

	// Transmitter FSM
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START, // Line driven low
		TX_DATA,
		TX_STOP // Line driven high
	} txState;

endpackage

// ==== uartTestPkg.sv ====
`include "uart_params.svh"

// Types for the receive buffer and the self test sequencer
package uartTestPkg;

	// Read and write addresses into the receive FIFO
	typedef logic [`FIFO_ADDR_BITS-1:0] fifoPtr;

	// Fill level, extra bit so that full is representable
	typedef logic [`FIFO_ADDR_BITS:0] fifoCount;

	// BIST sequencer
	typedef enum logic [1:0] {
		BIST_IDLE,
		BIST_SEND, // Offer pattern byte to the transmitter
		BIST_WAIT, // Wait for looped back byte or timeout
		BIST_DONE // One cycle to release the loopback
	} bistState;

endpackage

// ==== baudTimer.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

// Bit period counter on sysClk
// Gives one-cycle strobes at the middle and at the end of each bit
module baudTimer (
	input  logic sysClk,
	input  logic reset,
	input  logic restart, // Realign to a new bit boundary
	output logic midBit,
	output logic endBit
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam int LAST = `CLKS_PER_BIT - 1;
	localparam int HALF = (`CLKS_PER_BIT / 2) - 1; // Early by one to offset rx sync delay

	logic [CNT_W-1:0] count;

	//************************************************************
	// Counter, wraps every CLKS_PER_BIT cycles
	//************************************************************
	always_ff @(posedge sysClk) begin
		if (reset) begin
			count <= '0;
		end else if (restart) begin
			count <= '0; // Bit starts on the next cycle
		end else if (count == CNT_W'(LAST)) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Strobes decoded from the registered count
	assign midBit = (count == CNT_W'(HALF));
	assign endBit = (count == CNT_W'(LAST)); // Last cycle of the bit

endmodule

// ==== uartReceiver.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

// Serial receiver
// Falling edge starts a frame, every bit sampled at mid-bit
module uartReceiver import uartLinePkg::*; (
	input  logic    sysClk,
	input  logic    reset,
	input  logic    rx, // Asynchronous serial input
	output logic    byteValid, // One cycle per good frame
	output uartData byteData,
	output logic    rxError // One cycle per bad stop bit
);

	rxState  state;
	bitCount bitIdx; // Data bit, then stop bit index
	uartData shiftReg;
	logic    rxMeta;
	logic    rxSync;
	logic    rxPrev; // For edge detect
	logic    frameOk; // Cleared by any 0 stop bit
	logic    startEdge;
	logic    midBit;

	//************************************************************
	// Input synchronizer and start edge
	//************************************************************
	always_ff @(posedge sysClk) begin
		if (reset) begin
			rxMeta <= 1'b1; // Idle line is high
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end else begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	assign startEdge = (state == RX_IDLE) && rxPrev && !rxSync;

	baudTimer bitTimer (
		.sysClk,
		.reset,
		.restart(startEdge), // Align bit period to the start edge
		.midBit,
		.endBit() // Receiver works on mid-bit samples only
	);

	//************************************************************
	// Receive FSM
	//************************************************************
	always_ff @(posedge sysClk) begin
		if (reset) begin
			state <= RX_IDLE;
			bitIdx <= '0;
			frameOk <= 1'b0;
			byteValid <= 1'b0;
			rxError <= 1'b0;
		end else begin
			byteValid <= 1'b0; // Pulses by default
			rxError <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (startEdge)
						state <= RX_START;
				end
				RX_START: begin
					if (midBit) begin
						bitIdx <= '0;
						state <= rxSync ? RX_IDLE : RX_DATA; // High again means glitch
					end
				end
				RX_DATA: begin
					if (midBit) begin
						if (bitIdx == bitCount'(`DATA_BITS - 1)) begin
							bitIdx <= '0;
							frameOk <= 1'b1;
							state <= RX_STOP;
						end else begin
							bitIdx <= bitIdx + 1'b1;
						end
					end
				end
				RX_STOP: begin
					if (midBit) begin
						if (bitIdx == bitCount'(`STOP_BITS - 1)) begin
							byteValid <= frameOk && rxSync;
							rxError <= !(frameOk && rxSync); // Byte dropped
							state <= RX_IDLE;
						end else begin
							frameOk <= frameOk && rxSync;
							bitIdx <= bitIdx + 1'b1;
						end
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data shift, LSB arrives first so shift right
	always_ff @(posedge sysClk) begin
		if (state == RX_DATA && midBit)
			shiftReg <= {rxSync, shiftReg[`DATA_BITS-1:1]};
	end

	assign byteData = shiftReg; // Stable until the next frame

endmodule

// ==== uartTransmitter.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

// Serial transmitter with CTS gating
// Byte taken on valid/ready, frame starts once CTS is high
module uartTransmitter import uartLinePkg::*; (
	input  logic    sysClk,
	input  logic    reset,
	input  logic    txValid,
	input  uartData txData,
	output logic    txReady,
	input  logic    cts, // Peer ready to receive
	output logic    tx
);

	txState  state;
	bitCount bitIdx;
	uartData shiftReg;
	logic    pending; // Byte held, waiting for CTS
	logic    accept;
	logic    launch;
	logic    endBit;

	assign txReady = (state == TX_IDLE) && !pending;
	assign accept = txValid && txReady;
	assign launch = (state == TX_IDLE) && (accept || pending) && cts;

	baudTimer bitTimer (
		.sysClk,
		.reset,
		.restart(launch), // Start bit begins in the next cycle
		.midBit(), // Not needed on the transmit side
		.endBit
	);

	//************************************************************
	// Transmit FSM, registered line output
	//************************************************************
	always_ff @(posedge sysClk) begin
		if (reset) begin
			state <= TX_IDLE;
			bitIdx <= '0;
			pending <= 1'b0;
			tx <= 1'b1; // Line idles high
		end else begin
			case (state)
				TX_IDLE: begin
					if (launch) begin
						pending <= 1'b0;
						tx <= 1'b0; // Start bit
						state <= TX_START;
					end else if (accept) begin
						pending <= 1'b1; // CTS low, hold the byte
					end
				end
				TX_START: begin
					if (endBit) begin
						bitIdx <= '0;
						tx <= shiftReg[0];
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (endBit) begin
						if (bitIdx == bitCount'(`DATA_BITS - 1)) begin
							bitIdx <= '0;
							tx <= 1'b1; // First stop bit
							state <= TX_STOP;
						end else begin
							bitIdx <= bitIdx + 1'b1;
							tx <= shiftReg[0];
						end
					end
				end
				TX_STOP: begin
					if (endBit) begin
						if (bitIdx == bitCount'(`STOP_BITS - 1))
							state <= TX_IDLE;
						else
							bitIdx <= bitIdx + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Payload, loaded on handshake then shifted out LSB first
	always_ff @(posedge sysClk) begin
		if (accept)
			shiftReg <= txData;
		else if (endBit && (state == TX_START || state == TX_DATA))
			shiftReg <= shiftReg >> 1;
	end

endmodule

// ==== rxFifo.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

// Receive buffer, circular, show-ahead read port
module rxFifo import uartLinePkg::*, uartTestPkg::*; (
	input  logic    sysClk,
	input  logic    reset,
	input  logic    writeValid, // From receiver byte pulse
	input  uartData writeData,
	input  logic    bistMode, // Loopback bytes stay out of the buffer
	input  logic    rxReady,
	output logic    rxValid,
	output uartData rxData, // Head entry
	output logic    fifoFull,
	output logic    fifoOverflow,
	output logic    rts
);

	localparam int DEPTH = 2 ** `FIFO_ADDR_BITS;

	uartData  mem [DEPTH];
	fifoPtr   wrPtr;
	fifoPtr   rdPtr;
	fifoCount count;
	logic     writeReq;
	logic     doWrite;
	logic     popReq;

	assign writeReq = writeValid && !bistMode;
	assign popReq = rxValid && rxReady;
	assign doWrite = writeReq && (!fifoFull || popReq); // Pop frees a slot this edge

	assign rxValid = (count != '0);
	assign fifoFull = (count == fifoCount'(DEPTH));
	assign rts = (count < fifoCount'(`FIFO_RTS_LEVEL)); // Ask peer to pause near full
	assign rxData = mem[rdPtr];

	always_ff @(posedge sysClk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			fifoOverflow <= 1'b0;
		end else begin
			fifoOverflow <= writeReq && !doWrite; // Byte lost
			if (doWrite)
				wrPtr <= wrPtr + 1'b1; // Wraps at depth
			if (popReq)
				rdPtr <= rdPtr + 1'b1;
			case ({doWrite, popReq})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // None, or both
			endcase
		end
	end

	always_ff @(posedge sysClk) begin
		if (doWrite)
			mem[wrPtr] <= writeData;
	end

endmodule

// ==== bistController.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

// Loopback self test
// Sends an LFSR sequence through the transmitter and checks what comes back
module bistController import uartLinePkg::*, uartTestPkg::*; (
	input  logic    sysClk,
	input  logic    reset,
	input  logic    bistStart, // One-cycle request
	input  logic    byteValid, // Receiver pulse
	input  uartData byteData,
	input  logic    txReady,
	output logic    bistTxValid,
	output uartData bistTxData,
	output logic    bistMode, // Selects loopback in the top level
	output logic    bistBusy,
	output logic    bistError // Sticky until next start
);

	localparam int CNT_W = $clog2(`BIST_BYTES) + 1;
	localparam int TIMEOUT = 2 * (1 + `DATA_BITS + `STOP_BITS) * `CLKS_PER_BIT; // Two frames
	localparam int TO_W = $clog2(TIMEOUT + 1);

	bistState         state;
	logic [7:0]       lfsr; // Pattern, also the expected byte
	logic [CNT_W-1:0] byteCnt;
	logic [TO_W-1:0]  waitCnt;
	logic             timedOut;
	logic             lastByte;

	assign bistTxValid = (state == BIST_SEND);
	assign bistTxData = uartData'(lfsr); // Truncates for narrow frames
	assign bistBusy = (state != BIST_IDLE);
	assign bistMode = (state != BIST_IDLE);
	assign timedOut = (waitCnt == TO_W'(TIMEOUT));
	assign lastByte = (byteCnt == CNT_W'(`BIST_BYTES - 1));

	//************************************************************
	// Test sequencer
	//************************************************************
	always_ff @(posedge sysClk) begin
		if (reset) begin
			state <= BIST_IDLE;
			lfsr <= 8'hA5;
			byteCnt <= '0;
			waitCnt <= '0;
			bistError <= 1'b0;
		end else begin
			case (state)
				BIST_IDLE: begin
					if (bistStart) begin
						lfsr <= 8'hA5; // Seed
						byteCnt <= '0;
						bistError <= 1'b0;
						state <= BIST_SEND;
					end
				end
				BIST_SEND: begin
					waitCnt <= '0;
					if (txReady)
						state <= BIST_WAIT; // Byte taken by transmitter
				end
				BIST_WAIT: begin
					if (byteValid || timedOut) begin
						if (!byteValid || byteData != uartData'(lfsr))
							bistError <= 1'b1; // Miscompare or no response
						lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]}; // x^8+x^6+x^5+x^4+1
						byteCnt <= byteCnt + 1'b1;
						state <= lastByte ? BIST_DONE : BIST_SEND;
					end else begin
						waitCnt <= waitCnt + 1'b1;
					end
				end
				BIST_DONE: state <= BIST_IDLE; // Drops busy and mode
				default: state <= BIST_IDLE;
			endcase
		end
	end

endmodule

// ==== uartCore.sv ====
`timescale 1ns/1ps

// UART top level, receiver, transmitter, receive FIFO and self test
module uartCore import uartLinePkg::*; (
	input  logic    sysClk,
	input  logic    reset,
	input  logic    rx,
	output logic    tx,
	input  logic    cts,
	output logic    rts,
	input  logic    txValid,
	input  uartData txData,
	output logic    txReady,
	output logic    rxValid,
	output uartData rxData,
	input  logic    rxReady,
	output logic    rxError,
	output logic    fifoFull,
	output logic    fifoOverflow,
	input  logic    bistStart,
	output logic    bistBusy,
	output logic    bistError
);

	logic    bistMode;
	logic    rxIn; // Receiver serial input after loopback mux
	logic    txOut; // Transmitter serial output
	logic    coreTxValid;
	uartData coreTxData;
	logic    coreTxReady;
	logic    bistTxValid;
	uartData bistTxData;
	logic    byteValid; // Good frame pulse, to FIFO and BIST
	uartData byteData;

	//************************************************************
	// Loopback and handshake muxes
	//************************************************************
	assign rxIn = bistMode ? txOut : rx;
	assign tx = bistMode ? 1'b1 : txOut; // External line idle during test
	assign coreTxValid = bistMode ? bistTxValid : txValid;
	assign coreTxData = bistMode ? bistTxData : txData;
	assign txReady = bistMode ? 1'b0 : coreTxReady; // Host locked out

	uartReceiver receiver (
		.sysClk, .reset, .rx(rxIn), .byteValid, .byteData, .rxError
	);

	uartTransmitter transmitter (
		.sysClk, .reset, .txValid(coreTxValid), .txData(coreTxData),
		.txReady(coreTxReady), .cts, .tx(txOut)
	);

	rxFifo receiveFifo (
		.sysClk, .reset, .writeValid(byteValid), .writeData(byteData), .bistMode,
		.rxReady, .rxValid, .rxData, .fifoFull, .fifoOverflow, .rts
	);

	bistController selfTest (
		.sysClk, .reset, .bistStart, .byteValid, .byteData, .txReady(coreTxReady),
		.bistTxValid, .bistTxData, .bistMode, .bistBusy, .bistError
	);

endmodule

// ==== uartCore_tb.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

// Self-checking testbench for the UART subsystem
module uartCore_tb import uartLinePkg::*, uartTestPkg::*;;

	localparam int CPB = `CLKS_PER_BIT;
	localparam int FRAME_BITS = 1 + `DATA_BITS + `STOP_BITS;
	localparam int FRAME_CLKS = FRAME_BITS * CPB;
	localparam int DEPTH = 2 ** `FIFO_ADDR_BITS;
	// Rx, tx, held cts frame, overflow, framing, self test
	localparam int TOTAL_FRAMES = 20 + 20 + 1 + (DEPTH + 3) + 2 + `BIST_BYTES;
	localparam int CYCLE_LIMIT = TOTAL_FRAMES * FRAME_BITS * CPB * 2 + 2000;
	localparam int BIST_LIMIT = `BIST_BYTES * (2 * FRAME_CLKS + 8); // Worst case, every byte lost

	logic    sysClk;
	logic    reset;
	logic    rx;
	logic    tx;
	logic    cts;
	logic    rts;
	logic    txValid;
	uartData txData;
	logic    txReady;
	logic    rxValid;
	uartData rxData;
	logic    rxReady;
	logic    rxError;
	logic    fifoFull;
	logic    fifoOverflow;
	logic    bistStart;
	logic    bistBusy;
	logic    bistError;

	uartData  expQ[$]; // Bytes expected out of the receive FIFO
	uartData  sentQ[$]; // Bytes accepted by the transmitter
	fifoCount modelCount;
	int       cycles;
	int       rxErrPulses;
	int       ovfPulses;

	uartCore uut (.*);

	//************************************************************
	// Clock, watchdog and pulse monitors
	//************************************************************
	initial begin
		sysClk = 1'b0;
		forever #20 sysClk = ~sysClk;
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge sysClk);
			cycles++;
			if (cycles >= CYCLE_LIMIT) begin
				$display("Timeout after %0d cycles, the tests did not complete", cycles);
				abortRun();
			end
		end
	end

	always @(negedge sysClk) begin
		if (rxError)
			rxErrPulses++;
		if (fifoOverflow)
			ovfPulses++; // One per lost byte
	end

	//************************************************************
	// Compare tasks
	//************************************************************
	task automatic abortRun();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkByte(input string name, input uartData got, input uartData exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkCount(input string name, input fifoCount got, input fifoCount exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	//************************************************************
	// Line model
	//************************************************************
	task automatic waitCycles(input int n);
		repeat (n) @(posedge sysClk);
		#2; // Drive point
	endtask

	// Serialize one frame on rx, LSB first
	task automatic sendFrame(input uartData d, input logic stopVal);
		rx = 1'b0; // Start bit
		waitCycles(CPB);
		for (int i = 0; i < `DATA_BITS; i++) begin
			rx = d[i];
			waitCycles(CPB);
		end
		for (int s = 0; s < `STOP_BITS; s++) begin
			rx = stopVal;
			waitCycles(CPB);
		end
		rx = 1'b1;
	endtask

	// Deserialize one frame from tx, sampling mid-bit on the falling clock
	task automatic recvFrame(output uartData d);
		@(negedge sysClk);
		while (tx !== 1'b0)
			@(negedge sysClk);
		repeat (CPB / 2) @(negedge sysClk);
		checkFlag("tx start bit", tx, 1'b0);
		for (int i = 0; i < `DATA_BITS; i++) begin
			repeat (CPB) @(negedge sysClk);
			d[i] = tx;
		end
		for (int s = 0; s < `STOP_BITS; s++) begin
			repeat (CPB) @(negedge sysClk);
			checkFlag("tx stop bit", tx, 1'b1);
		end
	endtask

	// Hold txValid until the handshake edge
	task automatic offerByte(input uartData d);
		logic ready;
		txValid = 1'b1;
		txData = d;
		do begin
			@(negedge sysClk);
			ready = txReady;
			@(posedge sysClk);
		end while (!ready);
		#2;
		txValid = 1'b0;
		sentQ.push_back(d);
	endtask

	// Pop n bytes with random rxReady stalls, compare with the queue model
	task automatic popBytes(input int n);
		int got;
		got = 0;
		while (got < n) begin
			rxReady = (($urandom % 4) != 0);
			@(negedge sysClk);
			if (rxValid && rxReady) begin
				if (expQ.size() == 0) begin
					$display("Receive FIFO presented a byte that was never sent");
					abortRun();
				end
				checkByte("rxData", rxData, expQ.pop_front());
				got++;
			end
			@(posedge sysClk);
			#2;
		end
		rxReady = 1'b0;
	endtask

	//************************************************************
	// Test sequence
	//************************************************************
	initial begin
		uartData d;
		int busyCycles;
		void'($urandom(32'h037d_c993));
		reset = 1'b1;
		rx = 1'b1; // Idle line
		cts = 1'b1;
		txValid = 1'b0;
		txData = '0;
		rxReady = 1'b0;
		bistStart = 1'b0;
		rxErrPulses = 0;
		ovfPulses = 0;
		repeat (8) @(posedge sysClk);
		#2;
		reset = 1'b0;
		@(negedge sysClk);
		checkFlag("tx", tx, 1'b1);
		checkFlag("rts", rts, 1'b1);
		checkFlag("txReady", txReady, 1'b1);
		checkFlag("rxValid", rxValid, 1'b0);
		checkFlag("rxError", rxError, 1'b0);
		checkFlag("fifoOverflow", fifoOverflow, 1'b0);
		checkFlag("bistBusy", bistBusy, 1'b0);
		checkFlag("bistError", bistError, 1'b0);
		waitCycles(1);

		// Receive path, sender and reader run together
		fork
			for (int i = 0; i < 20; i++) begin
				d = uartData'($urandom);
				expQ.push_back(d); // Queued before the frame lands
				sendFrame(d, 1'b1);
			end
			popBytes(20);
		join
		checkCount("rxError pulses", fifoCount'(rxErrPulses), '0);

		// Transmit path with random valid gaps
		fork
			for (int i = 0; i < 20; i++) begin
				waitCycles($urandom % 4);
				offerByte(uartData'($urandom));
			end
			for (int i = 0; i < 20; i++) begin
				recvFrame(d);
				if (sentQ.size() == 0) begin
					$display("Frame on tx without an accepted byte");
					abortRun();
				end
				checkByte("tx byte", d, sentQ.pop_front());
			end
		join

		// CTS low holds an accepted byte
		waitCycles(1);
		cts = 1'b0;
		offerByte(uartData'($urandom));
		repeat (4 * FRAME_CLKS) begin
			@(negedge sysClk);
			checkFlag("tx while cts low", tx, 1'b1);
		end
		@(posedge sysClk);
		#2;
		cts = 1'b1;
		recvFrame(d);
		checkByte("tx byte after cts", d, sentQ.pop_front());
		waitCycles(1);

		// Fill past depth, rts and full follow the model count
		modelCount = '0;
		ovfPulses = 0;
		for (int i = 0; i < DEPTH + 3; i++) begin
			d = uartData'($urandom);
			sendFrame(d, 1'b1);
			if (modelCount < fifoCount'(DEPTH)) begin
				expQ.push_back(d);
				modelCount++;
			end
			checkCount("fifo count", uut.receiveFifo.count, modelCount);
			checkFlag("rts", rts, modelCount < fifoCount'(`FIFO_RTS_LEVEL));
			checkFlag("fifoFull", fifoFull, modelCount == fifoCount'(DEPTH));
		end
		checkCount("fifoOverflow pulses", fifoCount'(ovfPulses), fifoCount'(3));
		popBytes(DEPTH); // First DEPTH bytes intact
		checkFlag("rxValid after drain", rxValid, 1'b0);

		// Framing error leaves the FIFO alone
		d = uartData'($urandom);
		expQ.push_back(d);
		sendFrame(d, 1'b1);
		rxErrPulses = 0;
		sendFrame(uartData'($urandom), 1'b0); // Bad stop bit
		waitCycles(CPB);
		checkCount("rxError pulses", fifoCount'(rxErrPulses), fifoCount'(1));
		checkCount("fifo count", uut.receiveFifo.count, fifoCount'(1));
		popBytes(1);

		// Self test, FIFO empty beforehand
		bistStart = 1'b1;
		waitCycles(1);
		bistStart = 1'b0;
		@(negedge sysClk);
		checkFlag("bistBusy", bistBusy, 1'b1);
		busyCycles = 0;
		while (bistBusy) begin
			checkFlag("tx during self test", tx, 1'b1);
			checkFlag("txReady during self test", txReady, 1'b0);
			checkFlag("rxValid during self test", rxValid, 1'b0);
			busyCycles++;
			if (busyCycles > BIST_LIMIT) begin
				$display("Self test still busy after %0d cycles", busyCycles);
				abortRun();
			end
			@(negedge sysClk);
		end
		checkFlag("bistError", bistError, 1'b0);
		checkFlag("tx after self test", tx, 1'b1);

		$display("Test passed");
		$finish;
	end

endmodule

// ==== uartCore.f ====
+incdir+.
uartLinePkg.sv
uartTestPkg.sv
baudTimer.sv
uartReceiver.sv
uartTransmitter.sv
rxFifo.sv
bistController.sv
uartCore.sv
uartCore_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = uartCore_tb
FILELIST  = uartCore.f
BUILD     = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
